/* tcb_cfg.svh */
/*
  bus and memory sizing for the atomic TCB slice
  - byte addressing, full word accesses only
  - memory depth must be a power of two, at least 2
*/
`ifndef TCB_CFG_SVH
`define TCB_CFG_SVH

// byte address width
`define TCB_ADR 32

// data width, one full word per transfer
`define TCB_DAT 32

// memory size in words
`define TCB_MEM_DEPTH 16

`endif

/* tcb_pkg.sv */
/*
  shared TCB types
  - opcodes follow the RISC-V AMO funct5 codes
  - AMO_NONE uses a spare code and marks a plain read or write
  - widths come from the cfg header
*/
`include "tcb_cfg.svh"

package tcb_pkg;

  // transfer kind
  typedef enum logic [4:0] {
    AMO_ADD  = 5'b00000,
    AMO_SWAP = 5'b00001,
    AMO_XOR  = 5'b00100,
    AMO_OR   = 5'b01000,
    AMO_AND  = 5'b01100,
    AMO_MIN  = 5'b10000,
    AMO_MAX  = 5'b10100,
    AMO_MINU = 5'b11000,
    AMO_MAXU = 5'b11100,
    // plain read or write
    AMO_NONE = 5'b11111
  } tcb_amo_t;

  // response status
  typedef enum logic {
    TCB_STS_OK  = 1'b0,
    TCB_STS_ERR = 1'b1
  } tcb_sts_t;

  // request, held stable until rdy
  typedef struct packed {
    logic                wen;
    logic                ren;
    tcb_amo_t            amo;
    logic [`TCB_ADR-1:0] adr;
    logic [`TCB_DAT-1:0] wdt;
  } tcb_req_t;

  // response, valid in the transfer cycle
  typedef struct packed {
    logic [`TCB_DAT-1:0] rdt;
    tcb_sts_t            sts;
  } tcb_rsp_t;

endpackage

/* tcb_if.sv */
/*
  TCB point to point link
  - zero response delay, rsp valid while vld && rdy
  - single beat transfers, no lock, no bursts
*/

interface tcb_if
  import tcb_pkg::*;
();

  //////////////////////////////
  // handshake
  //////////////////////////////

  // request valid, from manager
  logic     vld;
  // ready, from subordinate
  logic     rdy;

  //////////////////////////////
  // payload
  //////////////////////////////

  tcb_req_t req;
  tcb_rsp_t rsp;

  // manager side
  modport man (
    output vld,
    output req,
    input  rdy,
    input  rsp
  );

  // subordinate side
  modport sub (
    input  vld,
    input  req,
    output rdy,
    output rsp
  );

endinterface

/* tcb_amo_rmw.sv */
/*
  atomic read-modify-write converter
  - sub side takes read, write and atomic transfers
  - man side sees plain transfers only, amo is always AMO_NONE
  - needs a subordinate with zero response delay and unclocked read
  - atomic transfers set both wen and ren, the old value is returned
  - purely combinational
*/
`include "tcb_cfg.svh"

module tcb_amo_rmw
  import tcb_pkg::*;
(
  // manager connects here
  tcb_if.sub sub,
  // memory connects here
  tcb_if.man man
);

  localparam int unsigned DAT = `TCB_DAT;

  // new write operand
  logic [DAT-1:0] wdt;
  // old memory value
  logic [DAT-1:0] rdt;
  // invert rdt, subtract for compares
  logic           inv;
  // unsigned order
  logic           uns;
  // second adder operand
  logic [DAT-1:0] op2;
  // sum with carry out
  logic [DAT:0]   sum;
  // wdt below rdt
  logic           lt;
  logic [DAT-1:0] log_res;
  logic [DAT-1:0] art_res;
  // combined value toward memory
  logic [DAT-1:0] wdt_new;

  assign wdt = sub.req.wdt;
  assign rdt = man.rsp.rdt;

  //////////////////////////////
  // arithmetic unit
  //////////////////////////////

  // adder mode per opcode
  always_comb begin
    case (sub.req.amo)
      AMO_MIN,
      AMO_MAX: begin
        inv = 1'b1;
        uns = 1'b0;
      end
      AMO_MINU,
      AMO_MAXU: begin
        inv = 1'b1;
        uns = 1'b1;
      end
      default: begin
        inv = 1'b0;
        uns = 1'b0;
      end
    endcase
  end

  // one adder, wdt + rdt or wdt - rdt
  assign op2 = inv ? ~rdt : rdt;
  assign sum = {1'b0, wdt} + {1'b0, op2} + {{DAT{1'b0}}, inv};

  // unsigned: no carry out means a borrow
  // signed: sign of the sign-extended difference
  assign lt = uns ? ~sum[DAT] : (wdt[DAT-1] ^ op2[DAT-1] ^ sum[DAT]);

  always_comb begin
    case (sub.req.amo)
      AMO_MIN,
      AMO_MINU: art_res = lt ? wdt : rdt;
      AMO_MAX,
      AMO_MAXU: art_res = lt ? rdt : wdt;
      // add
      default:  art_res = sum[DAT-1:0];
    endcase
  end

  //////////////////////////////
  // logic unit
  //////////////////////////////

  always_comb begin
    case (sub.req.amo)
      AMO_XOR: log_res = wdt ^ rdt;
      AMO_AND: log_res = wdt & rdt;
      AMO_OR:  log_res = wdt | rdt;
      default: log_res = wdt;
    endcase
  end

  //////////////////////////////
  // write data select
  //////////////////////////////

  always_comb begin
    case (sub.req.amo)
      // plain write and swap keep the manager data
      AMO_NONE,
      AMO_SWAP: wdt_new = wdt;
      AMO_XOR,
      AMO_AND,
      AMO_OR:   wdt_new = log_res;
      default:  wdt_new = art_res;
    endcase
  end

  //////////////////////////////
  // request and response
  //////////////////////////////

  // handshake straight through
  assign man.vld = sub.vld;
  assign sub.rdy = man.rdy;

  // memory sees a plain transfer
  assign man.req = '{
    wen: sub.req.wen,
    ren: sub.req.ren,
    amo: AMO_NONE,
    adr: sub.req.adr,
    wdt: wdt_new
  };

  // old value and status back unchanged
  assign sub.rsp = man.rsp;

endmodule

/* tcb_mem_sub.sv */
/*
  word memory subordinate
  - unclocked read, write on the edge ending the transfer
  - misaligned or out of range address gives an error, zero data, no write
  - all words cleared while rst is high
  - hold keeps rdy low, stands in for lost arbitration
*/
`include "tcb_cfg.svh"

module tcb_mem_sub
  import tcb_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic hold,
  tcb_if.sub   sub
);

  localparam int unsigned DEPTH = `TCB_MEM_DEPTH;
  localparam int unsigned IDX   = $clog2(DEPTH);

  // storage, one entry per word
  logic [`TCB_DAT-1:0] mem [DEPTH];
  // word address
  logic [`TCB_ADR-3:0] wrd;
  // array index
  logic [IDX-1:0]      idx;
  logic                err;
  logic                rdy;
  logic                wen;
  logic [`TCB_DAT-1:0] rdt;

  //////////////////////////////
  // decode
  //////////////////////////////

  assign wrd = sub.req.adr[`TCB_ADR-1:2];
  assign idx = wrd[IDX-1:0];

  // misaligned or past the last word
  assign err = (sub.req.adr[1:0] != 2'b00) || (wrd >= DEPTH);

  // no transfer during reset or hold
  assign rdy = ~rst & ~hold;

  // write only on a good handshake
  assign wen = sub.vld & rdy & sub.req.wen & ~err;

  //////////////////////////////
  // response
  //////////////////////////////

  // read is combinational, zero delay
  assign rdt = err ? '0 : mem[idx];

  assign sub.rdy = rdy;
  assign sub.rsp = '{
    rdt: rdt,
    sts: err ? TCB_STS_ERR : TCB_STS_OK
  };

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wen) begin
      mem[idx] <= sub.req.wdt;
    end
  end

endmodule

/* tcb_amo_top.sv */
/*
  TCB atomic slice top level
  - plain manager ports, one transfer per cycle with vld && rdy
  - rdt and sts valid in the transfer cycle itself
  - atomic transfers set wen and ren, rdt returns the old value
  - hold stalls the memory, req must stay stable meanwhile
*/
`include "tcb_cfg.svh"

module tcb_amo_top
  import tcb_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                hold,
  // request
  input  logic                vld,
  input  logic                wen,
  input  logic                ren,
  input  tcb_amo_t            amo,
  input  logic [`TCB_ADR-1:0] adr,
  input  logic [`TCB_DAT-1:0] wdt,
  // response
  output logic                rdy,
  output logic [`TCB_DAT-1:0] rdt,
  output tcb_sts_t            sts
);

  // manager to converter
  tcb_if bus_amo ();
  // converter to memory
  tcb_if bus_mem ();

  //////////////////////////////
  // port mapping, manager side
  //////////////////////////////

  assign bus_amo.vld = vld;
  assign bus_amo.req = '{wen: wen, ren: ren, amo: amo, adr: adr, wdt: wdt};

  assign rdy = bus_amo.rdy;
  assign rdt = bus_amo.rsp.rdt;
  assign sts = bus_amo.rsp.sts;

  //////////////////////////////
  // datapath
  //////////////////////////////

  // atomic ops become plain writes
  tcb_amo_rmw u_tcb_amo_rmw (
    .sub (bus_amo),
    .man (bus_mem)
  );

  tcb_mem_sub u_tcb_mem_sub (
    .clk  (clk),
    .rst  (rst),
    .hold (hold),
    .sub  (bus_mem)
  );

endmodule

/* tcb_amo_asserts.sv */
/*
  bound checks on the memory side of the bus
  - bound into every tcb_mem_sub instance
  - memory compared as one flat vector for small depths
*/
`include "tcb_cfg.svh"

module tcb_amo_asserts
  import tcb_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                vld,
  input logic                rdy,
  input tcb_req_t            req,
  input tcb_sts_t            sts,
  input logic [`TCB_DAT-1:0] mem [`TCB_MEM_DEPTH]
);

  localparam int unsigned DEPTH = `TCB_MEM_DEPTH;
  localparam int unsigned DAT   = `TCB_DAT;

  // all words side by side
  logic [DEPTH*DAT-1:0] flat;

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      flat[i*DAT +: DAT] = mem[i];
    end
  end

  // stalled request must wait unchanged
  assert property (@(posedge clk) disable iff (rst) (vld && !rdy) |=> $stable(req))
    else $error("request changed while stalled");

  // no transfer during reset and every word cleared by it
  assert property (@(posedge clk) rst |-> (!rdy ##1 (flat == '0)))
    else $error("rdy high or memory not cleared during reset");

  // error transfer leaves memory alone
  assert property (@(posedge clk) disable iff (rst)
                   (vld && rdy && sts == TCB_STS_ERR) |=> flat == $past(flat))
    else $error("memory changed on an error transfer");

endmodule

bind tcb_mem_sub tcb_amo_asserts u_tcb_amo_asserts (
  .clk (clk),
  .rst (rst),
  .vld (sub.vld),
  .rdy (sub.rdy),
  .req (sub.req),
  .sts (sub.rsp.sts),
  .mem (mem)
);

/* tcb_amo_tb.sv */
/*
  testbench for the atomic TCB slice
  - vectors and expected responses come from tcb_amo_golden.txt
  - run from the project root so the vector file is found
  - rdt is compared on reads and on error responses only
  - inputs change 1 unit after the rising edge and outputs are sampled mid cycle
  - one result line per test id over its consecutive vectors
*/
`include "tcb_cfg.svh"

module tcb_amo_tb
  import tcb_pkg::*;
();

  logic                clk;
  logic                rst;
  logic                hold;
  logic                vld;
  logic                wen;
  logic                ren;
  tcb_amo_t            amo;
  logic [`TCB_ADR-1:0] adr;
  logic [`TCB_DAT-1:0] wdt;
  logic                rdy;
  logic [`TCB_DAT-1:0] rdt;
  tcb_sts_t            sts;

  // filler data for reads
  integer seed;
  // watchdog limit in time units, set once vectors are loaded
  time    limit = 0;
  int     n_pass = 0;
  int     n_fail = 0;

  //////////////////////////////
  // vector storage
  //////////////////////////////

  int                  q_id   [$];
  int                  q_hold [$];
  logic                q_wen  [$];
  logic                q_ren  [$];
  logic [4:0]          q_amo  [$];
  logic [`TCB_ADR-1:0] q_adr  [$];
  logic [`TCB_DAT-1:0] q_wdt  [$];
  logic [`TCB_DAT-1:0] q_rdt  [$];
  logic                q_sts  [$];

  tcb_amo_top u_tcb_amo_top (
    .clk  (clk),
    .rst  (rst),
    .hold (hold),
    .vld  (vld),
    .wen  (wen),
    .ren  (ren),
    .amo  (amo),
    .adr  (adr),
    .wdt  (wdt),
    .rdy  (rdy),
    .rdt  (rdt),
    .sts  (sts)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // lines starting with # are column notes
  task automatic load_vectors();
    int                  fd;
    int                  n;
    string               line;
    int                  id;
    int                  hc;
    logic                w;
    logic                r;
    logic                s;
    logic [4:0]          op;
    logic [`TCB_ADR-1:0] a;
    logic [`TCB_DAT-1:0] d;
    logic [`TCB_DAT-1:0] e;
    fd = $fopen("tcb_amo_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tcb_amo_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %b %b %h %h %h %h %b", id, hc, w, r, op, a, d, e, s);
          if (n == 9) begin
            q_id.push_back(id);
            q_hold.push_back(hc);
            q_wen.push_back(w);
            q_ren.push_back(r);
            q_amo.push_back(op);
            q_adr.push_back(a);
            q_wdt.push_back(d);
            q_rdt.push_back(e);
            q_sts.push_back(s);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one transfer entered and left 1 unit after a rising edge
  task automatic run_transfer(input int k, output int errs);
    logic [`TCB_DAT-1:0] got_rdt;
    tcb_sts_t            got_sts;
    errs = 0;
    vld  = 1'b1;
    wen  = q_wen[k];
    ren  = q_ren[k];
    amo  = tcb_amo_t'(q_amo[k]);
    adr  = q_adr[k];
    wdt  = q_wen[k] ? q_wdt[k] : $random(seed);
    hold = (q_hold[k] > 0);
    // stalled cycles where the memory must not accept
    for (int c = 0; c < q_hold[k]; c++) begin
      #4;
      assert (rdy === 1'b0) else begin
        $display("[ERROR] %0t rdy expected 0 got %b", $time, rdy);
        errs++;
      end
      @(posedge clk);
      #1;
    end
    hold = 1'b0;
    #4;
    // wait for the memory to accept
    while (rdy !== 1'b1) begin
      @(posedge clk);
      #5;
    end
    got_rdt = rdt;
    got_sts = sts;
    assert (got_sts === tcb_sts_t'(q_sts[k])) else begin
      $display("[ERROR] %0t sts expected %b got %b", $time, q_sts[k], got_sts);
      errs++;
    end
    if (q_ren[k] || q_sts[k]) begin
      assert (got_rdt === q_rdt[k]) else begin
        $display("[ERROR] %0t rdt expected %h got %h", $time, q_rdt[k], got_rdt);
        errs++;
      end
    end
    // transfer takes place on this edge
    @(posedge clk);
    #1;
    vld = 1'b0;
  endtask

  // close one test id and print its result
  task automatic report_test(input int id, input int errs);
    if (errs == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d: %s", id, (errs == 0) ? "ok" : "mismatch");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int max_hold;
    int errs;
    int test_errs;
    seed      = 32'h1a304268;
    rst       = 1'b1;
    hold      = 1'b0;
    vld       = 1'b0;
    wen       = 1'b0;
    ren       = 1'b0;
    amo       = AMO_NONE;
    adr       = '0;
    wdt       = '0;
    max_hold  = 0;
    errs      = 0;
    test_errs = 0;
    load_vectors();
    foreach (q_hold[i]) begin
      if (q_hold[i] > max_hold) begin
        max_hold = q_hold[i];
      end
    end
    // at most hold + 4 cycles per line plus reset
    limit = q_id.size() * (max_hold + 4) * 10 + 5 * 10;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int k = 0; k < q_id.size(); k++) begin
      run_transfer(k, errs);
      test_errs += errs;
      // last vector of this test id
      if (k == q_id.size() - 1 || q_id[k + 1] != q_id[k]) begin
        report_test(q_id[k], test_errs);
        test_errs = 0;
      end
    end
    $display("vectors %0d, tests passed %0d, tests failed %0d", q_id.size(), n_pass, n_fail);
    if (n_fail == 0 && n_pass > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit > 0);
    #(limit);
    $display("timeout, transfers did not complete within %0t time units", limit);
    $display("Checks failed");
    $finish;
  end

endmodule

/* tcb_amo_golden.txt */
# id hold wen ren amo adr wdt exp_rdt exp_sts (amo hex, 1f plain; hold in cycles)
# rdt compared on reads and errors; wdt of reads is replaced by filler
1 0 0 1 1f 00000000 00000000 00000000 0
1 0 0 1 1f 00000004 00000000 00000000 0
1 0 0 1 1f 00000008 00000000 00000000 0
1 0 0 1 1f 0000000c 00000000 00000000 0
1 0 0 1 1f 00000010 00000000 00000000 0
1 0 0 1 1f 00000014 00000000 00000000 0
1 0 0 1 1f 00000018 00000000 00000000 0
1 0 0 1 1f 0000001c 00000000 00000000 0
1 0 0 1 1f 00000020 00000000 00000000 0
1 0 0 1 1f 00000024 00000000 00000000 0
1 0 0 1 1f 00000028 00000000 00000000 0
1 0 0 1 1f 0000002c 00000000 00000000 0
1 0 0 1 1f 00000030 00000000 00000000 0
1 0 0 1 1f 00000034 00000000 00000000 0
1 0 0 1 1f 00000038 00000000 00000000 0
1 0 0 1 1f 0000003c 00000000 00000000 0
2 0 1 0 1f 00000000 a5a5a5a5 00000000 0
2 0 1 0 1f 00000004 12345678 00000000 0
2 0 0 1 1f 00000000 00000000 a5a5a5a5 0
2 0 0 1 1f 00000004 00000000 12345678 0
3 0 1 0 1f 00000008 000000ff 00000000 0
3 0 1 1 01 00000008 0f0f0f0f 000000ff 0
3 0 0 1 1f 00000008 00000000 0f0f0f0f 0
4 0 1 0 1f 0000000c 7fffffff 00000000 0
4 0 1 1 00 0000000c 00000002 7fffffff 0
4 0 0 1 1f 0000000c 00000000 80000001 0
5 0 1 1 0c 00000000 0ff00ff0 a5a5a5a5 0
5 0 0 1 1f 00000000 00000000 05a005a0 0
6 0 1 1 08 00000004 80000001 12345678 0
6 0 0 1 1f 00000004 00000000 92345679 0
7 0 1 1 04 00000008 ffff0000 0f0f0f0f 0
7 0 0 1 1f 00000008 00000000 f0f00f0f 0
8 0 1 0 1f 00000010 fffffff0 00000000 0
8 0 1 1 10 00000010 00000010 fffffff0 0
8 0 0 1 1f 00000010 00000000 fffffff0 0
9 0 1 1 18 00000010 00000010 fffffff0 0
9 0 0 1 1f 00000010 00000000 00000010 0
10 0 1 0 1f 00000014 00000005 00000000 0
10 0 1 1 14 00000014 80000000 00000005 0
10 0 0 1 1f 00000014 00000000 00000005 0
11 0 1 1 1c 00000014 80000000 00000005 0
11 0 0 1 1f 00000014 00000000 80000000 0
12 0 1 0 1f 00000002 deadbeef 00000000 1
12 0 1 0 1f 00000040 deadbeef 00000000 1
12 0 1 1 00 00000042 00000001 00000000 1
12 0 0 1 1f 00000041 00000000 00000000 1
12 0 0 1 1f 00000000 00000000 05a005a0 0
12 0 0 1 1f 0000003c 00000000 00000000 0
13 3 1 1 00 0000000c 00000001 80000001 0
13 2 0 1 1f 0000000c 00000000 80000002 0
13 4 1 0 1f 00000018 cafef00d 00000000 0
13 0 0 1 1f 00000018 00000000 cafef00d 0

/* vlog.f */
+incdir+.
tcb_pkg.sv
tcb_if.sv
tcb_amo_rmw.sv
tcb_mem_sub.sv
tcb_amo_top.sv
tcb_amo_asserts.sv
tcb_amo_tb.sv

/* Bender.yml */
package:
  name: tcb_amo

sources:
  - include_dirs:
      - .
    files:
      - tcb_pkg.sv
      - tcb_if.sv
      - tcb_amo_rmw.sv
      - tcb_mem_sub.sv
      - tcb_amo_top.sv
      - target: test
        files:
          - tcb_amo_asserts.sv
          - tcb_amo_tb.sv
